/* sdram_dev_pkg.sv */
// SDR SDRAM pin-level definitions; every timing count assumes a clock where each wait is 2 cycles, no refresh
package sdram_dev_pkg;

    // command word is {cs_n, ras_n, cas_n, we_n}
    typedef logic [3:0]  sdram_cmd_t;
    typedef logic [12:0] sdram_addr_t;   // multiplexed row/column address
    typedef logic [1:0]  sdram_dqm_t;    // {dqmh, dqml}

    localparam sdram_cmd_t nop       = 4'b0111;
    localparam sdram_cmd_t active    = 4'b0011;
    localparam sdram_cmd_t read      = 4'b0101;
    localparam sdram_cmd_t write     = 4'b0100;
    localparam sdram_cmd_t precharge = 4'b0010;   // a[10] low selects one bank

    // everything the controller puts on the device pins except DQ
    typedef struct packed {
        sdram_cmd_t  cmd;
        sdram_addr_t a;     // row on active, column on read/write
        logic [1:0]  ba;
        sdram_dqm_t  dqm;   // held low while read data is due
    } sdram_pins_t;

    localparam int t_rp  = 2;   // precharge to active, same bank
    localparam int t_rcd = 2;   // active to read/write, same bank
    localparam int t_rrd = 2;   // active to active, any two banks

    // read burst length programmed in the device, writes use single-location mode
    localparam int burst_len = 4;

endpackage

/* ctrl_types_pkg.sv */
// controller-side types; 24-bit word address split bank/row/column, one 16-bit word per location
package ctrl_types_pkg;
    import sdram_dev_pkg::*;

    localparam int n_banks = 4;

    typedef logic [12:0] row_t;
    typedef logic [8:0]  col_t;
    typedef logic [1:0]  bank_t;
    typedef logic [15:0] word_t;
    typedef logic [63:0] line_t;    // read burst, beat 0 in the low word

    // host word address, msb first
    typedef struct packed {
        bank_t bank;
        row_t  row;
        col_t  col;
    } addr_t;

    typedef struct packed {
        logic  rd;
        logic  wr;
        addr_t addr;
        word_t wdata;   // ignored on reads
    } host_req_t;

    // contents of one bank slot, bank number is implied by the slot
    typedef struct packed {
        logic  rd;
        logic  wr;
        row_t  row;
        col_t  col;
        word_t wdata;
    } bank_req_t;

    // a bank's bid for the pin bus
    typedef struct packed {
        logic        br;      // bus request
        sdram_cmd_t  cmd;
        sdram_addr_t a;
        word_t       wdata;
    } bank_cmd_t;

    // busy windows, OR-ed over all banks by the arbiter
    typedef struct packed {
        logic dbusy;      // read burst still being issued, no new READ
        logic dqm_busy;   // read data due on DQ, no WRITE
        logic post_act;   // tRRD window after an ACTIVE
    } bank_stat_t;

    typedef struct packed {
        bank_t bank;
        line_t data;
    } rd_rsp_t;

    typedef enum logic [2:0] {
        idle, prech, wait_rp, act, wait_rcd, access, data
    } bank_state_e;

endpackage

/* req_dispatch.sv */
// one slot per bank; a request to a full slot waits with host_ack low, host must not set rd and wr together
`timescale 1ns/100ps

module req_dispatch import ctrl_types_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  host_req_t               host_req,
    output logic                    host_ack,
    output bank_req_t [n_banks-1:0] slot_req,
    input  logic      [n_banks-1:0] bank_ack
);

    logic  [n_banks-1:0] slot_rd;     // slot holds a read
    logic  [n_banks-1:0] slot_wr;     // slot holds a write
    logic  [n_banks-1:0] slot_full;
    row_t                slot_row   [n_banks];
    col_t                slot_col   [n_banks];
    word_t               slot_wdata [n_banks];
    logic                req_any;

    assign req_any   = host_req.rd | host_req.wr;
    assign slot_full = slot_rd | slot_wr;
    assign host_ack  = req_any & ~slot_full[host_req.addr.bank];   // bank decode from top bits

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slot_rd <= '0;
            slot_wr <= '0;
        end else begin
            for (int i = 0; i < n_banks; i++) begin
                if (bank_ack[i]) begin   // bank took it, slot free next cycle
                    slot_rd[i] <= 1'b0;
                    slot_wr[i] <= 1'b0;
                end
            end
            // ack only goes to an empty slot so it never meets a bank_ack
            if (host_ack) begin
                slot_rd[host_req.addr.bank] <= host_req.rd;
                slot_wr[host_req.addr.bank] <= host_req.wr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (host_ack) begin
            slot_row[host_req.addr.bank]   <= host_req.addr.row;
            slot_col[host_req.addr.bank]   <= host_req.addr.col;
            slot_wdata[host_req.addr.bank] <= host_req.wdata;
        end
    end

    always_comb begin
        for (int i = 0; i < n_banks; i++) begin
            slot_req[i] = '{rd: slot_rd[i], wr: slot_wr[i], row: slot_row[i],
                            col: slot_col[i], wdata: slot_wdata[i]};
        end
    end

endmodule

/* bank_seq.sv */
// one bank's sequencer; row stays open after an access, tRAS and tWR are not enforced here
`timescale 1ns/100ps

module bank_seq import sdram_dev_pkg::*, ctrl_types_pkg::*; #(
    parameter int cas_lat = 2
) (
    input  logic       clk,
    input  logic       rst,
    input  bank_req_t  slot_req,
    output logic       bank_ack,
    input  logic       grant,
    input  bank_stat_t all_stat,
    output bank_cmd_t  bank_cmd,
    output bank_stat_t bank_stat
);

    bank_state_e state;
    bank_state_e eff_state;   // state as seen this cycle, idle resolved to its first step
    bank_state_e next_state;
    logic [1:0]  wait_cnt;    // t_rp, t_rcd and burst countdown
    logic [2:0]  dqm_cnt;     // cycles until our read data has left DQ
    logic [1:0]  act_cnt;     // tRRD after our ACTIVE
    logic        row_open;
    row_t        open_row;
    logic        pending;
    logic        row_hit;
    logic        fire;        // our command is on the pins this cycle

    assign pending = slot_req.rd | slot_req.wr;
    assign row_hit = row_open && (open_row == slot_req.row);
    assign fire    = bank_cmd.br & grant;

    // deciding in idle itself lets a row hit bid in the cycle after host_ack
    always_comb begin
        eff_state = state;
        if (state == idle && pending) begin
            if (row_hit)       eff_state = access;
            else if (row_open) eff_state = prech;   // wrong row open
            else               eff_state = act;
        end
    end

    // bid only when legal against the other banks' windows
    always_comb begin
        bank_cmd.br    = 1'b0;
        bank_cmd.cmd   = nop;
        bank_cmd.a     = '0;
        bank_cmd.wdata = slot_req.wdata;
        case (eff_state)
            prech: begin
                bank_cmd.br  = 1'b1;
                bank_cmd.cmd = precharge;
            end
            act: begin
                bank_cmd.br  = ~all_stat.post_act;
                bank_cmd.cmd = active;
                bank_cmd.a   = slot_req.row;
            end
            access: begin
                if (slot_req.rd) begin
                    bank_cmd.br  = ~all_stat.dbusy;   // bursts back to back, never overlapped
                    bank_cmd.cmd = read;
                end else begin
                    bank_cmd.br  = ~(all_stat.dbusy | all_stat.dqm_busy);   // DQ must be free
                    bank_cmd.cmd = write;
                end
                bank_cmd.a = sdram_addr_t'(slot_req.col);   // a[10] low, no auto-precharge
            end
            default: ;
        endcase
    end

    assign bank_ack = fire && (eff_state == access);

    always_comb begin
        next_state = eff_state;
        case (eff_state)
            prech:    if (fire) next_state = wait_rp;
            wait_rp:  if (wait_cnt == 2'd1) next_state = act;
            act:      if (fire) next_state = wait_rcd;
            wait_rcd: if (wait_cnt == 2'd1) next_state = access;
            access:   if (fire) next_state = slot_req.rd ? data : idle;   // writes end at once
            data:     if (wait_cnt == 2'd1) next_state = idle;
            default:  ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= idle;
            wait_cnt <= '0;
            dqm_cnt  <= '0;
            act_cnt  <= '0;
            row_open <= 1'b0;
        end else begin
            state <= next_state;

            if (fire) begin
                case (eff_state)
                    prech:   wait_cnt <= 2'(t_rp - 1);
                    act:     wait_cnt <= 2'(t_rcd - 1);
                    default: wait_cnt <= 2'(burst_len - 1);   // rest of the burst slot
                endcase
            end else if (wait_cnt != '0) begin
                wait_cnt <= wait_cnt - 2'd1;
            end

            if (fire && eff_state == access && slot_req.rd)
                dqm_cnt <= 3'(cas_lat + burst_len - 1);   // up to the last beat on DQ
            else if (dqm_cnt != '0)
                dqm_cnt <= dqm_cnt - 3'd1;

            if (fire && eff_state == act)
                act_cnt <= 2'(t_rrd - 1);
            else if (act_cnt != '0)
                act_cnt <= act_cnt - 2'd1;

            if (fire && eff_state == act)   row_open <= 1'b1;
            if (fire && eff_state == prech) row_open <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fire && eff_state == act) open_row <= slot_req.row;
    end

    assign bank_stat.dbusy    = (state == data);
    assign bank_stat.dqm_busy = (dqm_cnt != '0);
    assign bank_stat.post_act = (act_cnt != '0);

endmodule

/* cmd_arbiter.sv */
// one command per cycle with rotating priority; needs cas_lat >= 2 and bursts that never overlap
`timescale 1ns/100ps

module cmd_arbiter import sdram_dev_pkg::*, ctrl_types_pkg::*; #(
    parameter int cas_lat = 2
) (
    input  logic                     clk,
    input  logic                     rst,
    input  bank_cmd_t  [n_banks-1:0] bank_cmd,
    input  bank_stat_t [n_banks-1:0] bank_stat,
    output logic       [n_banks-1:0] grant,
    output bank_stat_t               all_stat,
    output sdram_pins_t              pins,
    output word_t                    dq_out,
    output logic                     dq_oe,
    input  word_t                    dq_in,
    output rd_rsp_t                  rd_rsp,
    output logic                     rsp_valid
);

    bank_t               rr_ptr;     // first bank looked at
    bank_t               gnt_idx;
    logic                gnt_any;
    bank_cmd_t           gnt_cmd;
    logic                rd_issue;
    logic [cas_lat-1:0]  tag_v;      // reads in flight, one stage per CAS cycle
    bank_t [cas_lat-1:0] tag_bank;
    logic [1:0]          beat_cnt;   // 0 when no burst is arriving
    logic [47:0]         beat_buf;   // beats 0 to 2, newest on top
    bank_t               cur_bank;

    always_comb begin
        bank_t idx;
        grant   = '0;
        gnt_idx = rr_ptr;
        gnt_any = 1'b0;
        for (int k = 0; k < n_banks; k++) begin
            idx = rr_ptr + bank_t'(k);
            if (!gnt_any && bank_cmd[idx].br) begin
                grant[idx] = 1'b1;
                gnt_idx    = idx;
                gnt_any    = 1'b1;
            end
        end
    end

    assign gnt_cmd  = bank_cmd[gnt_idx];
    assign rd_issue = gnt_any && (gnt_cmd.cmd == read);

    always_comb begin
        all_stat = '0;
        for (int k = 0; k < n_banks; k++) all_stat = all_stat | bank_stat[k];
    end

    always_comb begin
        pins.cmd = gnt_any ? gnt_cmd.cmd : nop;
        pins.a   = gnt_any ? gnt_cmd.a : '0;
        pins.ba  = gnt_idx;
        // dqm low from the READ until its last beat so no beat gets masked
        pins.dqm = (all_stat.dqm_busy || (gnt_any && gnt_cmd.cmd inside {read, write}))
                   ? 2'b00 : 2'b11;
    end

    assign dq_oe  = gnt_any && (gnt_cmd.cmd == write);   // write data in the command cycle
    assign dq_out = gnt_cmd.wdata;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rr_ptr    <= '0;
            tag_v     <= '0;
            beat_cnt  <= '0;
            rsp_valid <= 1'b0;
        end else begin
            if (gnt_any) rr_ptr <= gnt_idx + 2'd1;   // winner goes to the back
            tag_v     <= {tag_v[cas_lat-2:0], rd_issue};
            rsp_valid <= 1'b0;
            if (tag_v[cas_lat-1]) begin
                beat_cnt <= 2'd1;   // beat 0 on dq_in now
            end else if (beat_cnt != '0) begin
                beat_cnt  <= beat_cnt + 2'd1;
                rsp_valid <= (beat_cnt == 2'(burst_len - 1));
            end
        end
    end

    always_ff @(posedge clk) begin
        tag_bank <= {tag_bank[cas_lat-2:0], gnt_idx};
        if (tag_v[cas_lat-1]) begin
            cur_bank <= tag_bank[cas_lat-1];
            beat_buf <= {dq_in, beat_buf[47:16]};
        end else if (beat_cnt == 2'(burst_len - 1)) begin
            rd_rsp.bank <= cur_bank;
            rd_rsp.data <= {dq_in, beat_buf};   // last beat goes straight to the top word
        end else if (beat_cnt != '0) begin
            beat_buf <= {dq_in, beat_buf[47:16]};
        end
    end

endmodule

/* sdram_ctrl_top.sv */
// controller top; no refresh or init sequence, the device must come up ready at the same CAS latency
`timescale 1ns/100ps

module sdram_ctrl_top import sdram_dev_pkg::*, ctrl_types_pkg::*; #(
    parameter int cas_lat = 2   // 2 or 3
) (
    input  logic        clk,
    input  logic        rst,
    input  host_req_t   host_req,
    output logic        host_ack,
    output rd_rsp_t     rd_rsp,
    output logic        rsp_valid,
    output sdram_pins_t pins,
    output word_t       dq_out,
    output logic        dq_oe,
    input  word_t       dq_in
);

    bank_req_t  [n_banks-1:0] slot_req;    // dispatcher to banks
    logic       [n_banks-1:0] bank_ack;
    bank_cmd_t  [n_banks-1:0] bank_cmd;    // bids
    bank_stat_t [n_banks-1:0] bank_stat;
    logic       [n_banks-1:0] grant;
    bank_stat_t               all_stat;    // merged windows back to every bank

    req_dispatch u_dispatch (
        .clk      (clk),
        .rst      (rst),
        .host_req (host_req),
        .host_ack (host_ack),
        .slot_req (slot_req),
        .bank_ack (bank_ack)
    );

    for (genvar i = 0; i < n_banks; i++) begin : g_bank
        bank_seq #(.cas_lat(cas_lat)) u_bank (
            .clk       (clk),
            .rst       (rst),
            .slot_req  (slot_req[i]),
            .bank_ack  (bank_ack[i]),
            .grant     (grant[i]),
            .all_stat  (all_stat),
            .bank_cmd  (bank_cmd[i]),
            .bank_stat (bank_stat[i])
        );
    end

    cmd_arbiter #(.cas_lat(cas_lat)) u_arb (
        .clk       (clk),
        .rst       (rst),
        .bank_cmd  (bank_cmd),
        .bank_stat (bank_stat),
        .grant     (grant),
        .all_stat  (all_stat),
        .pins      (pins),
        .dq_out    (dq_out),
        .dq_oe     (dq_oe),
        .dq_in     (dq_in),
        .rd_rsp    (rd_rsp),
        .rsp_valid (rsp_valid)
    );

endmodule

/* sdram_model.sv */
// behavioral SDRAM, comes up ready with no refresh; sequential read bursts, single-word writes, dqm ignored
`timescale 1ns/100ps

module sdram_model import sdram_dev_pkg::*; #(
    parameter int cas_lat = 2   // must match the controller
) (
    input  logic        clk,
    input  sdram_pins_t pins,
    input  logic [15:0] wdq,      // write data from the controller
    input  logic        wdq_oe,
    output logic [15:0] rdq       // read data back to the controller
);

    logic [15:0] mem [bit [23:0]];             // only words that were written
    logic [12:0] open_row [4];                 // last ACTIVE row per bank
    logic        sched_v [16] = '{default: 1'b0};   // beat slots, indexed by cycle
    logic [23:0] sched_a [16];
    logic [15:0] rdq_r = '0;
    int unsigned cyc = 0;

    assign rdq = rdq_r;

    // unwritten words read back as a pattern of the full word address
    function automatic logic [15:0] fill_word(input logic [23:0] addr);
        return {addr[23:16] ^ addr[15:8], addr[7:0]};
    endfunction

    always @(posedge clk) begin
        logic [23:0] a;
        int          slot;
        slot = cyc % 16;
        if (sched_v[slot]) begin   // a beat is due on DQ this cycle
            a = sched_a[slot];
            rdq_r <= mem.exists(a) ? mem[a] : fill_word(a);
            sched_v[slot] = 1'b0;
        end
        case (pins.cmd)
            active: open_row[pins.ba] = pins.a;
            read: begin
                for (int b = 0; b < burst_len; b++) begin
                    slot = (cyc + cas_lat - 1 + b) % 16;   // beat 0 cas_lat cycles after READ
                    sched_v[slot] = 1'b1;
                    // column wraps inside the burst
                    sched_a[slot] = {pins.ba, open_row[pins.ba], pins.a[8:2],
                                     2'(pins.a[1:0] + b)};
                end
            end
            write: begin
                if (wdq_oe)
                    mem[{pins.ba, open_row[pins.ba], pins.a[8:0]}] = wdq;
            end
            default: ;   // nop, precharge
        endcase
        cyc++;
    end

endmodule

/* sdram_ctrl_props.sv */
// pin-bus timing checks for the controller; single chip select, tRP and tRCD taken from the device package
`timescale 1ns/100ps

module sdram_ctrl_props import sdram_dev_pkg::*; (
    input logic        clk,
    input logic        rst,
    input sdram_pins_t pins,
    input logic        rsp_valid
);

    int unsigned fail_cnt = 0;   // failed assertions so far
    logic        rw_cmd;

    assign rw_cmd = (pins.cmd == read) || (pins.cmd == write);

    for (genvar b = 0; b < 4; b++) begin : g_bank
        // column command too soon after the row opened
        a_rcd: assert property (@(posedge clk) disable iff (rst)
            (pins.cmd == active && pins.ba == b) |=> !(rw_cmd && pins.ba == b) [*(t_rcd-1)])
        else begin
            $error("bank %0d: READ or WRITE less than tRCD after ACTIVE", b);
            fail_cnt++;
        end

        a_rp: assert property (@(posedge clk) disable iff (rst)
            (pins.cmd == precharge && pins.ba == b) |=>
                !(pins.cmd == active && pins.ba == b) [*(t_rp-1)])
        else begin
            $error("bank %0d: ACTIVE less than tRP after PRECHARGE", b);
            fail_cnt++;
        end
    end

    // bursts back to back at most, any bank
    a_burst: assert property (@(posedge clk) disable iff (rst)
        (pins.cmd == read) |=> (pins.cmd != read) [*(burst_len-1)])
    else begin
        $error("READ issued while the previous burst is still pending");
        fail_cnt++;
    end

    a_rst: assert property (@(posedge clk) rst |-> !rsp_valid)
    else begin
        $error("rsp_valid high during reset");
        fail_cnt++;
    end

endmodule

bind sdram_ctrl_top sdram_ctrl_props u_props (
    .clk       (clk),
    .rst       (rst),
    .pins      (pins),
    .rsp_valid (rsp_valid)
);

/* tb_sdram_ctrl.sv */
// controller testbench at CAS latency 3; reads sdram_stimulus.txt from the run directory, at most 64 lines
`timescale 1ns/100ps

module tb_sdram_ctrl import sdram_dev_pkg::*, ctrl_types_pkg::*;;

    localparam int cas_lat    = 3;
    localparam int clk_period = 4;
    localparam int max_lines  = 64;
    localparam int n_cols     = 6;   // op, addr, data, acts, pres, test

    logic        clk;
    logic        rst;
    host_req_t   host_req;
    logic        host_ack;
    rd_rsp_t     rd_rsp;
    logic        rsp_valid;
    sdram_pins_t pins;
    word_t       dq_out;
    logic        dq_oe;
    word_t       dq_in;

    logic [63:0] stim [max_lines*n_cols];
    logic [65:0] exp_q [$];            // {bank, line} in issue order
    logic        loaded = 1'b0;
    int          n_lines = 0;
    int          err_cnt = 0;
    int          chk_cnt = 0;
    int          test_err = 0;
    int          act_cnt = 0;          // pin commands seen in the current test
    int          pre_cnt = 0;
    int          rsp_cnt = 0;
    int          quiet_cnt = 0;        // NOP cycles in a row
    int          issued [n_banks] = '{default: 0};   // requests accepted per bank
    int          done [n_banks] = '{default: 0};     // READ/WRITE seen per bank

    sdram_ctrl_top #(.cas_lat(cas_lat)) dut (
        .clk       (clk),
        .rst       (rst),
        .host_req  (host_req),
        .host_ack  (host_ack),
        .rd_rsp    (rd_rsp),
        .rsp_valid (rsp_valid),
        .pins      (pins),
        .dq_out    (dq_out),
        .dq_oe     (dq_oe),
        .dq_in     (dq_in)
    );

    sdram_model #(.cas_lat(cas_lat)) u_model (
        .clk    (clk),
        .pins   (pins),
        .wdq    (dq_out),
        .wdq_oe (dq_oe),
        .rdq    (dq_in)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period/2) clk = ~clk;
    end

    task automatic check_val(input string what, input logic [79:0] got, input logic [79:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            test_err++;
            $display("error at %0t: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic check_idle(input string when);
        check_val({"pin cmd ", when}, pins.cmd, nop);
        check_val({"dq_oe ", when}, dq_oe, 1'b0);
        check_val({"rsp_valid ", when}, rsp_valid, 1'b0);
    endtask

    // hold one request until acked, then queue the expected line for reads
    task automatic send_req(input int idx);
        logic [63:0] op;
        logic [23:0] addr;
        logic [63:0] dat;
        bank_t       b;
        op   = stim[idx*n_cols];
        addr = stim[idx*n_cols+1][23:0];
        dat  = stim[idx*n_cols+2];
        b    = addr[23:22];
        host_req <= '{rd: (op == 2), wr: (op == 1), addr: addr_t'(addr), wdata: dat[15:0]};
        @(posedge clk);
        while (!host_ack) @(posedge clk);
        check_val("bank accepted before its previous request issued", done[b], issued[b]);
        issued[b]++;
        if (op == 2)
            exp_q.push_back({b, dat});
    endtask

    // all reads answered and the pin bus quiet
    task automatic wait_drain();
        @(negedge clk);
        while (exp_q.size() != 0 || quiet_cnt < 12) @(negedge clk);
        @(posedge clk);
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (pins.cmd == nop)
                quiet_cnt++;
            else
                quiet_cnt = 0;
            if (pins.cmd == active) act_cnt++;
            if (pins.cmd == precharge) pre_cnt++;
            if (pins.cmd inside {read, write}) begin
                done[pins.ba]++;
                check_val("dqm on READ or WRITE", pins.dqm, 2'b00);   // no byte masks
            end
            if (rsp_valid) begin
                rsp_cnt++;
                if (exp_q.size() == 0) begin
                    err_cnt++;
                    test_err++;
                    $display("response from bank %0d with no read outstanding", rd_rsp.bank);
                end else begin
                    check_val("read line", {14'b0, rd_rsp}, exp_q.pop_front());
                end
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (n_lines * 40 + 8) @(posedge clk);   // plus reset cycles
        $display("timeout: responses missing");
        $display("sim failed");
        $finish;
    end

    initial begin
        int line;
        int t;
        int exp_act;
        int exp_pre;
        int n_rd;
        int n_tests;
        rst      <= 1'b1;
        host_req <= '0;
        $readmemh("sdram_stimulus.txt", stim);
        while (n_lines < max_lines && stim[n_lines*n_cols] === 64'd1
               || n_lines < max_lines && stim[n_lines*n_cols] === 64'd2)
            n_lines++;
        loaded = 1'b1;

        repeat (3) begin
            @(posedge clk);
            check_idle("in reset");
        end
        rst <= 1'b0;
        repeat (2) begin
            @(posedge clk);
            check_idle("after reset");
        end
        $display("test 0: %0d errors", test_err);
        n_tests = 1;

        line = 0;
        while (line < n_lines) begin
            t        = stim[line*n_cols+5];
            test_err = 0;
            act_cnt  = 0;
            pre_cnt  = 0;
            rsp_cnt  = 0;
            exp_act  = 0;
            exp_pre  = 0;
            n_rd     = 0;
            while (line < n_lines && stim[line*n_cols+5] == t) begin   // one test group
                exp_act += stim[line*n_cols+3];
                exp_pre += stim[line*n_cols+4];
                if (stim[line*n_cols] == 2)
                    n_rd++;
                send_req(line);
                line++;
            end
            host_req <= '0;
            wait_drain();
            check_val("ACTIVE count", act_cnt, exp_act);
            check_val("PRECHARGE count", pre_cnt, exp_pre);
            check_val("response count", rsp_cnt, n_rd);
            $display("test %0d: %0d errors", t, test_err);
            n_tests++;
        end

        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 n_tests, chk_cnt, err_cnt, dut.u_props.fail_cnt);
        if (err_cnt == 0 && dut.u_props.fail_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* sdram_stimulus.txt */
// op (1 write, 2 read), word address {bank,row,col}, write word or expected line {beat3..beat0}
// ACTIVEs expected, PRECHARGEs expected, test number
1 000a10 1234 1 0 1
2 000a10 0a13_0a12_0a11_1234 0 0 1
1 000a24 beef 0 0 2
2 000a24 0a27_0a26_0a25_beef 0 0 2
2 000a10 0a13_0a12_0a11_1234 0 0 2
2 000a24 0a27_0a26_0a25_beef 0 0 3
2 03e608 e50b_e50a_e509_e508 1 1 3
1 03e60a 0f0f 0 0 3
2 03e608 e50b_0f0f_e509_e508 0 0 3
1 03e60c a000 0 0 4
1 400500 a111 1 0 4
1 8ffffc a222 1 0 4
1 e00040 a333 1 0 4
2 03e60c e50f_e50e_e50d_a000 0 0 5
2 400500 4503_4502_4501_a111 0 0 5
2 8ffffc 70ff_70fe_70fd_a222 0 0 5
2 e00040 e043_e042_e041_a333 0 0 5
1 400504 c0de 0 0 6
2 400504 4507_4506_4505_c0de 0 0 6
2 8ffffc 70ff_70fe_70fd_a222 0 0 6
2 800600 8603_8602_8601_8600 1 1 6

/* build.f */
sdram_dev_pkg.sv
ctrl_types_pkg.sv
req_dispatch.sv
bank_seq.sv
cmd_arbiter.sv
sdram_ctrl_top.sv
sdram_model.sv
sdram_ctrl_props.sv
tb_sdram_ctrl.sv
